// ==== run.sh ====
#!/bin/sh
# build and run the envelope generator testbench with Verilator
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module eg_tb -f verilog.f -o eg_sim > sim.log 2>&1 \
	&& ./obj_dir/eg_sim >> sim.log 2>&1
grep -qx ">>> PASS" sim.log && echo "simulation passed" || { echo "simulation failed, see sim.log"; exit 1; }

// ==== verification/eg_clkgen.sv ====
`default_nettype none
`timescale 1ns/1ps

module eg_clkgen #(
	parameter int half_ns    = 10, // 20 ns period
	parameter int rst_cycles = 4
) (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever #half_ns clk = ~clk;
	end

	// release on a falling edge, away from the capture edge
	initial begin
		rst = 1'b1;
		repeat (rst_cycles) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
	end

endmodule

`default_nettype wire

// ==== verification/eg_tb.sv ====
`default_nettype none
`timescale 1ns/1ps
`include "eg_consts.svh"

module eg_tb;

	import eg_pkg::*;

	localparam int clk_ns      = 20;
	localparam int watchdog_ns = 400 * `EG_SLOTS * clk_ns; // 400 rounds
	localparam int chk_free    = 0; // no check on this slot
	localparam int chk_equal   = 1; // eg_out must equal exp_val
	localparam int chk_fall    = 2; // never increases
	localparam int chk_rise    = 3; // never decreases

	logic                  clk, rst, wr, eg_out_valid;
	logic [`EG_SLOT_W-1:0] wr_slot, eg_out_slot, exp_slot;
	eg_op_t                wr_op;
	logic [`EG_DATA_W-1:0] wr_data;
	logic [`EG_W-1:0]      eg_out, hold_val;
	int                    mode [`EG_SLOTS];
	logic [`EG_W-1:0]      exp_val [`EG_SLOTS];
	logic [`EG_W-1:0]      seen [`EG_SLOTS]; // last output per slot
	logic [`EG_SLOTS-1:0]  used;
	logic [`EG_SLOT_W-1:0] sa, sb, sc, se;   // one slot per test
	logic [6:0]            tl_rand;
	logic                  valid_seen;       // first output reached
	int                    n;

	eg_clkgen #(.half_ns (clk_ns / 2), .rst_cycles (4)) u_clkgen (.clk (clk), .rst (rst));

	eg_top dut0 (
		.clk (clk), .rst (rst),
		.wr (wr), .wr_slot (wr_slot), .wr_op (wr_op), .wr_data (wr_data),
		.eg_out (eg_out), .eg_out_slot (eg_out_slot), .eg_out_valid (eg_out_valid)
	);

	//////////////////////////////////////////////////
	// reference and compare helpers
	//////////////////////////////////////////////////
	function automatic logic [`EG_W-1:0] eg_ref_out(input logic [`EG_W-1:0] att,
			input logic [6:0] tl);
		logic [`EG_W:0] sum;
		sum = {1'b0, att} + {1'b0, tl, 3'b000}; // tl counts 8 lsb
		return sum[`EG_W] ? {`EG_W{1'b1}} : sum[`EG_W-1:0];
	endfunction

	task automatic error_stop(input string msg);
		$display("%s", msg);
		$display(">>> FAIL");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_eg(input string name, input logic [`EG_W-1:0] got,
			input logic [`EG_W-1:0] exp);
		if (got !== exp)
			error_stop($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
	endtask

	task automatic check_slot(input string name, input logic [`EG_SLOT_W-1:0] got,
			input logic [`EG_SLOT_W-1:0] exp);
		if (got !== exp)
			error_stop($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
	endtask

	task automatic check_valid(input string name, input logic got, input logic exp);
		if (got !== exp)
			error_stop($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
	endtask

	task automatic write_reg(input logic [`EG_SLOT_W-1:0] s, input eg_op_t op,
			input logic [`EG_DATA_W-1:0] data);
		@(negedge clk);
		wr      = 1'b1;
		wr_slot = s;
		wr_op   = op;
		wr_data = data;
		@(negedge clk);
		wr      = 1'b0; // one clock strobe
	endtask

	task automatic wait_rounds(input int r);
		repeat (r * `EG_SLOTS) @(negedge clk);
	endtask

	task automatic pick_slot(output logic [`EG_SLOT_W-1:0] s);
		int k;
		k = $urandom % `EG_SLOTS;
		while (used[k])
			k = $urandom % `EG_SLOTS; // distinct slots per test
		used[k] = 1'b1;
		s = `EG_SLOT_W'(k);
	endtask

	//////////////////////////////////////////////////
	// output monitor sees one slot per clock
	//////////////////////////////////////////////////
	always @(negedge clk) begin
		if (!rst) begin
			if (valid_seen)
				check_valid("eg_out_valid", eg_out_valid, 1'b1); // high once started
			if (eg_out_valid === 1'b1) begin
				valid_seen = 1'b1;
				check_slot("eg_out_slot", eg_out_slot, exp_slot);
				exp_slot = (exp_slot == `EG_SLOT_W'(`EG_SLOTS - 1)) ? '0 : exp_slot + 1'b1;
				case (mode[eg_out_slot])
					chk_equal: check_eg($sformatf("eg_out[slot %0d]", eg_out_slot), eg_out,
						exp_val[eg_out_slot]);
					chk_fall: if (eg_out > seen[eg_out_slot])
						error_stop($sformatf("eg_out of slot %0d rose from %h to %h in attack",
							eg_out_slot, seen[eg_out_slot], eg_out));
					chk_rise: if (eg_out < seen[eg_out_slot])
						error_stop($sformatf("eg_out of slot %0d fell from %h to %h",
							eg_out_slot, seen[eg_out_slot], eg_out));
					default: ;
				endcase
				seen[eg_out_slot] = eg_out;
			end
		end
	end

	// watchdog
	initial begin
		#(watchdog_ns);
		$display("run took longer than 400 rounds, watchdog expired");
		$display(">>> FAIL");
		$fatal(1, "timeout");
	end

	//////////////////////////////////////////////////
	// stimulus
	//////////////////////////////////////////////////
	initial begin
		void'($urandom(2));
		wr         = 1'b0;
		wr_slot    = '0;
		wr_op      = op_ar;
		wr_data    = '0;
		exp_slot   = '0;
		used       = '0;
		valid_seen = 1'b0;
		for (int i = 0; i < `EG_SLOTS; i++) begin
			mode[i]    = chk_equal; // idle slots stay silent
			exp_val[i] = '1;
			seen[i]    = '1;
		end
		pick_slot(sa);
		pick_slot(sb);
		pick_slot(sc);
		pick_slot(se);
		while (rst) @(negedge clk);
		wait_rounds(3); // idle rounds after reset

		// instant attack and tl offset then hold
		mode[sa] = chk_free;
		tl_rand  = 7'($urandom % 128);
		write_reg(sa, op_tl, {1'b0, tl_rand});
		write_reg(sa, op_ar, 8'd31);
		write_reg(sa, op_d1r, 8'd0);
		write_reg(sa, op_key, 8'd1);
		wait_rounds(2);
		exp_val[sa] = eg_ref_out('0, tl_rand);
		mode[sa]    = chk_equal;
		wait_rounds(3);

		// attack rate 20 and keycode 16 at key scale 3 give rate 56
		mode[sb] = chk_fall;
		write_reg(sb, op_ks_kc, 8'hd0);
		write_reg(sb, op_ar, 8'd20);
		write_reg(sb, op_key, 8'd1);
		for (n = 0; n < 200 && seen[sb] != '0; n++)
			wait_rounds(1);
		if (seen[sb] != '0)
			error_stop($sformatf("attack on slot %0d never reached zero", sb));
		exp_val[sb] = '0;
		mode[sb]    = chk_equal;

		// decay1 up to sustain level 3
		mode[sc] = chk_free;
		write_reg(sc, op_rr_d1l, 8'h30);
		write_reg(sc, op_ar, 8'd31);
		write_reg(sc, op_key, 8'd1);
		wait_rounds(2);
		exp_val[sc] = '0;
		mode[sc]    = chk_equal;
		wait_rounds(1);
		mode[sc] = chk_rise;
		write_reg(sc, op_d1r, 8'd31);
		for (n = 0; n < 60 && seen[sc][`EG_W-1 -: 5] != 5'd3; n++)
			wait_rounds(1);
		wait_rounds(3);
		hold_val = seen[sc];
		check_eg("eg_out[9:5]", `EG_W'(hold_val[`EG_W-1 -: 5]), `EG_W'(3));
		exp_val[sc] = hold_val;
		mode[sc]    = chk_equal; // sustain rate 0 holds
		wait_rounds(3);

		// release rate 15 from part way down the attack
		mode[se] = chk_fall;
		write_reg(se, op_ks_kc, 8'hd0);
		write_reg(se, op_ar, 8'd20);
		write_reg(se, op_key, 8'd1);
		for (n = 0; n < 20 && seen[se] == '1; n++)
			wait_rounds(1);
		if (seen[se] == '1)
			error_stop($sformatf("attack on slot %0d did not start", se));
		mode[se] = chk_free;
		write_reg(se, op_rr_d1l, 8'h0f);
		write_reg(se, op_key, 8'd0);
		wait_rounds(2);
		mode[se] = chk_rise;
		for (n = 0; n < 150 && seen[se] != '1; n++)
			wait_rounds(1);
		if (seen[se] != '1)
			error_stop($sformatf("release on slot %0d never reached full attenuation", se));
		exp_val[se] = '1;
		mode[se]    = chk_equal;
		wait_rounds(3);

		// large total level with and without saturation
		mode[sa] = chk_free;
		write_reg(sa, op_tl, 8'd127);
		wait_rounds(2);
		exp_val[sa] = eg_ref_out('0, 7'd127);
		mode[sa]    = chk_equal;
		wait_rounds(2);
		check_eg("eg_out at tl 127", seen[sa], 10'h3f8);
		mode[sc] = chk_free;
		write_reg(sc, op_tl, 8'd127);
		wait_rounds(2);
		exp_val[sc] = eg_ref_out(hold_val, 7'd127);
		mode[sc]    = chk_equal;
		wait_rounds(2);
		check_eg("eg_out saturated", seen[sc], 10'h3ff);

		$display(">>> PASS");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+verilog
verilog/eg_pkg.sv
verilog/eg_slot_ring.sv
verilog/eg_timer.sv
verilog/eg_regs.sv
verilog/eg_rate.sv
verilog/eg_core.sv
verilog/eg_top.sv
verification/eg_clkgen.sv
verification/eg_tb.sv

// ==== verilog/eg_consts.svh ====
`ifndef EG_CONSTS_SVH
`define EG_CONSTS_SVH

// slot sequencing
`define EG_SLOTS   24 // operator slots per round
`define EG_SLOT_W  5  // slot index
`define EG_W       10 // attenuation, 1 lsb is about 0.094 dB
`define EG_CNT_W   15 // global envelope counter

// register fields
`define EG_DATA_W  8  // write data bus
`define EG_RATE_W  5  // ar, d1r, d2r
`define EG_RR_W    4  // rr and d1l
`define EG_TL_W    7  // total level
`define EG_KS_W    2  // key scale
`define EG_KC_W    5  // keycode

`endif

// ==== verilog/eg_core.sv ====
`default_nettype none
`timescale 1ns/1ps
`include "eg_consts.svh"

module eg_core (
	input  wire                   clk,
	input  wire                   rst,
	input  wire                   keyon,     // stage one
	input  wire                   keyoff,
	input  wire [`EG_RATE_W-1:0]  arate,
	input  wire [`EG_RATE_W-1:0]  rate1,
	input  wire [`EG_RATE_W-1:0]  rate2,
	input  wire [`EG_RR_W-1:0]    rrate,
	input  wire [`EG_RR_W-1:0]    d1l,
	input  wire [`EG_TL_W-1:0]    tl,
	output eg_pkg::eg_state_t     state_sel, // stage two
	output logic [`EG_RATE_W-1:0] cfg_sel,
	input  wire [5:0]             rate,      // stage three
	input  wire                   step,
	input  wire                   sum_up,
	output logic [`EG_W-1:0]      eg_out,    // stage five
	output logic                  eg_out_valid
);

	import eg_pkg::*;

	localparam int ring_len = `EG_SLOTS - 3; // three pipe regs close the round
	localparam int ring_w   = 3 + `EG_W;     // state and attenuation

	logic [ring_w-1:0]     ring_din, ring_dout, ring_q;
	logic [`EG_SLOT_W-1:0] fill_cnt;  // clocks since reset
	logic                  fill_done; // ring holds real data
	eg_state_t             prev_state, next_state, state_3, state_4;
	logic [`EG_W-1:0]      prev_att, att_2, att_3, att_4, att_next;
	logic [`EG_RR_W:0]     d1level;
	logic [`EG_RATE_W-1:0] next_cfg;
	logic                  ar_max_2, ar_max_3; // attack rate 31
	logic [`EG_TL_W-1:0]   tl_2, tl_3, tl_4;
	logic [8:0]            ar_sum0;
	logic [`EG_W-1:0]      ar_sum, ar_result;
	logic [3:0]            inc;
	logic [`EG_W:0]        dec_sum, out_sum; // carry bit for saturation
	logic [4:0]            vld;

	//////////////////////////////////////////////////
	// ring readout, idle values until first fill
	//////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (rst)
			fill_cnt <= '0;
		else if (!fill_done)
			fill_cnt <= fill_cnt + 1'b1;
	end

	assign fill_done  = (fill_cnt == `EG_SLOT_W'(ring_len));
	assign ring_q     = fill_done ? ring_dout : {eg_release, {`EG_W{1'b1}}};
	assign prev_state = eg_state_t'(ring_q[ring_w-1 -: 3]);
	assign prev_att   = ring_q[`EG_W-1:0];

	//////////////////////////////////////////////////
	// stage one, state decision
	//////////////////////////////////////////////////
	always_comb begin
		d1level    = (d1l == '1) ? 5'h10 : {1'b0, d1l}; // 15 means 48 dB
		next_state = prev_state;
		next_cfg   = rate2;
		if (keyoff) begin
			next_state = eg_release;
			next_cfg   = {rrate, 1'b1};
		end else if (keyon && prev_state == eg_release) begin
			next_state = eg_attack;
			next_cfg   = arate;
		end else begin
			case (prev_state)
				eg_attack: begin
					if (prev_att == '0) begin
						next_state = eg_decay1; // peak reached
						next_cfg   = rate1;
					end else begin
						next_cfg = arate;
					end
				end
				eg_decay1: begin
					if (prev_att[`EG_W-1 -: 5] >= d1level) begin
						next_state = eg_decay2; // sustain level hit
						next_cfg   = rate2;
					end else begin
						next_cfg = rate1;
					end
				end
				eg_decay2: next_cfg = rate2;
				default: begin
					next_state = eg_release;
					next_cfg   = {rrate, 1'b1};
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state_sel <= eg_release;
			cfg_sel   <= '0;
			att_2     <= '1;
			state_3   <= eg_release;
			att_3     <= '1;
		end else begin
			state_sel <= next_state;
			cfg_sel   <= next_cfg;
			att_2     <= prev_att;
			state_3   <= state_sel; // stage two to three
			att_3     <= att_2;
		end
	end

	// side band, lined up with the slot
	always_ff @(posedge clk) begin
		ar_max_2 <= (arate == '1);
		ar_max_3 <= ar_max_2;
		tl_2     <= tl;
		tl_3     <= tl_2;
		tl_4     <= tl_3;
	end

	//////////////////////////////////////////////////
	// stage three, attenuation update
	//////////////////////////////////////////////////
	always_comb begin
		case (rate[5:2])
			4'd13: ar_sum0 = 9'(att_3[`EG_W-1:3]) + 9'd1;
			4'd14, 4'd15: ar_sum0 = 9'(att_3[`EG_W-1:2]) + 9'd1;
			default: ar_sum0 = 9'(att_3[`EG_W-1:4]) + 9'd1; // att/16 + 1
		endcase
		if (rate[5:4] == 2'b11)
			ar_sum = step ? {ar_sum0, 1'b0} : {1'b0, ar_sum0};
		else
			ar_sum = step ? {1'b0, ar_sum0} : '0;
		ar_result = (ar_sum < att_3) ? att_3 - ar_sum : '0; // no wrap below 0
	end

	// linear step for decay and release
	always_comb begin
		case (rate[5:2])
			4'd12: inc = step ? 4'd2 : 4'd1;
			4'd13: inc = step ? 4'd4 : 4'd2;
			4'd14: inc = step ? 4'd8 : 4'd4;
			4'd15: inc = 4'd8;
			default: inc = {3'd0, step};
		endcase
		dec_sum = {1'b0, att_3} + {{(`EG_W - 3){1'b0}}, inc};
	end

	always_comb begin
		att_next = att_3; // hold by default
		if (state_3 == eg_attack) begin
			if (ar_max_3)
				att_next = '0; // instant attack
			else if (sum_up && att_3 != '0)
				att_next = ar_result;
		end else if (sum_up) begin
			att_next = dec_sum[`EG_W] ? '1 : dec_sum[`EG_W-1:0];
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state_4 <= eg_release;
			att_4   <= '1; // silent
		end else begin
			state_4 <= state_3;
			att_4   <= att_next;
		end
	end

	assign ring_din = {state_4, att_4};

	eg_slot_ring #(
		.width  (ring_w),
		.stages (ring_len)
	) u_state_ring (
		.clk  (clk),
		.din  (ring_din),
		.dout (ring_dout)
	);

	//////////////////////////////////////////////////
	// stage four, total level and saturation
	//////////////////////////////////////////////////
	assign out_sum = {1'b0, att_4} + {1'b0, tl_4, 3'b000}; // tl in 0.75 dB units

	always_ff @(posedge clk) begin
		eg_out <= out_sum[`EG_W] ? '1 : out_sum[`EG_W-1:0];
	end

	// valid once slot 0 has crossed all five stages
	always_ff @(posedge clk) begin
		if (rst)
			vld <= '0;
		else
			vld <= {vld[3:0], 1'b1};
	end

	assign eg_out_valid = vld[4];

endmodule

`default_nettype wire

// ==== verilog/eg_pkg.sv ====
`default_nettype none

package eg_pkg;

	//////////////////////////////////////////////////
	// envelope phase of one slot
	//////////////////////////////////////////////////

	// release is the idle phase after reset
	typedef enum logic [2:0] {
		eg_attack  = 3'd0, // level falls towards 0
		eg_decay1  = 3'd1, // rises until sustain level
		eg_decay2  = 3'd2, // sustain rate, no end point
		eg_release = 3'd3  // rises to silence
	} eg_state_t;

	//////////////////////////////////////////////////
	// write opcodes
	//////////////////////////////////////////////////

	// field layout within wr_data
	typedef enum logic [2:0] {
		op_ar     = 3'd0, // [4:0] attack rate
		op_d1r    = 3'd1, // [4:0] decay rate
		op_d2r    = 3'd2, // [4:0] sustain rate
		op_rr_d1l = 3'd3, // [3:0] release rate, [7:4] sustain level
		op_tl     = 3'd4, // [6:0] total level
		op_ks_kc  = 3'd5, // [7:6] key scale, [4:0] keycode
		op_key    = 3'd6  // [0] key on
	} eg_op_t;

endpackage

`default_nettype wire

// ==== verilog/eg_rate.sv ====
`default_nettype none
`timescale 1ns/1ps
`include "eg_consts.svh"

module eg_rate (
	input  wire                   clk,
	input  wire                   rst,
	input  var  eg_pkg::eg_state_t state,   // stage two
	input  wire [`EG_RATE_W-1:0]  cfg,      // stage two
	input  wire [`EG_KS_W-1:0]    ks,       // stage one
	input  wire [`EG_KC_W-1:0]    keycode,  // stage one
	input  wire [`EG_CNT_W-1:0]   eg_cnt,
	output logic [5:0]            rate,     // stage three
	output logic                  step,
	output logic                  sum_up
);

	import eg_pkg::*;

	eg_state_t             state_d;  // lined up with rate
	logic [`EG_KS_W-1:0]   ks_d;
	logic [`EG_KC_W-1:0]   kc_d;
	logic [`EG_KC_W-1:0]   kc_shift; // keycode after key scale
	logic [6:0]            pre_rate;
	logic [3:0]            cnt_sh;
	logic [2:0]            cnt_sel;  // counter window
	logic [7:0]            step_idx;
	logic                  cnt_last; // window lsb at last visit

	//////////////////////////////////////////////////
	// stage two, key scaled rate
	//////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		ks_d <= ks;
		kc_d <= keycode;
	end

	assign kc_shift = kc_d >> (2'd3 - ks_d);

	always_comb begin
		if (cfg == '0)
			pre_rate = '0; // rate 0 stays 0 regardless of keycode
		else
			pre_rate = {1'b0, cfg, 1'b0} + {2'b00, kc_shift};
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			rate    <= '0;
			state_d <= eg_release;
		end else begin
			rate    <= pre_rate[6] ? 6'd63 : pre_rate[5:0]; // clamp
			state_d <= state;
		end
	end

	//////////////////////////////////////////////////
	// stage three, counter window and step pattern
	//////////////////////////////////////////////////
	always_comb begin
		if (state_d == eg_attack)
			cnt_sh = (rate[5:2] > 4'd10) ? 4'd0 : 4'd11 - rate[5:2]; // attack one bit faster
		else
			cnt_sh = (rate[5:2] > 4'd11) ? 4'd0 : 4'd12 - rate[5:2];
	end

	assign cnt_sel = 3'(eg_cnt >> cnt_sh);

	always_comb begin
		if (rate[5:4] == 2'b11) begin
			if (rate[5:2] == 4'hf && state_d == eg_attack)
				step_idx = 8'b11111111; // fastest attack
			else
				case (rate[1:0])
					2'd0: step_idx = 8'b00000000;
					2'd1: step_idx = 8'b10001000;
					2'd2: step_idx = 8'b10101010;
					default: step_idx = 8'b11101110;
				endcase
		end else begin
			if (rate[5:2] == 4'd0 && state_d != eg_attack)
				step_idx = 8'b11111110; // slowest decay limit
			else
				case (rate[1:0])
					2'd0: step_idx = 8'b10101010;
					2'd1: step_idx = 8'b11101010;
					2'd2: step_idx = 8'b11101110;
					default: step_idx = 8'b11111110;
				endcase
		end
	end

	assign step = (rate == '0) ? 1'b0 : step_idx[cnt_sel]; // rate 0 holds

	// window lsb of each slot, one round back
	eg_slot_ring #(
		.width  (1),
		.stages (`EG_SLOTS)
	) u_cnt_ring (
		.clk  (clk),
		.din  (cnt_sel[0]),
		.dout (cnt_last)
	);

	assign sum_up = (cnt_sel[0] != cnt_last);

endmodule

`default_nettype wire

// ==== verilog/eg_regs.sv ====
`default_nettype none
`timescale 1ns/1ps
`include "eg_consts.svh"

module eg_regs (
	input  wire                   clk,
	input  wire                   rst,
	input  wire                   wr,      // one cycle write strobe
	input  wire [`EG_SLOT_W-1:0]  wr_slot,
	input  var  eg_pkg::eg_op_t   wr_op,
	input  wire [`EG_DATA_W-1:0]  wr_data,
	input  wire [`EG_SLOT_W-1:0]  slot,    // slot to read out
	output logic [`EG_RATE_W-1:0] arate,
	output logic [`EG_RATE_W-1:0] rate1,
	output logic [`EG_RATE_W-1:0] rate2,
	output logic [`EG_RR_W-1:0]   rrate,
	output logic [`EG_RR_W-1:0]   d1l,
	output logic [`EG_TL_W-1:0]   tl,
	output logic [`EG_KS_W-1:0]   ks,
	output logic [`EG_KC_W-1:0]   keycode,
	output logic                  keyon,   // key 0 to 1 since last visit
	output logic                  keyoff   // key 1 to 0 since last visit
);

	import eg_pkg::*;

	// one entry per slot
	logic [`EG_RATE_W-1:0] ar_mem  [`EG_SLOTS];
	logic [`EG_RATE_W-1:0] d1r_mem [`EG_SLOTS];
	logic [`EG_RATE_W-1:0] d2r_mem [`EG_SLOTS];
	logic [`EG_RR_W-1:0]   rr_mem  [`EG_SLOTS];
	logic [`EG_RR_W-1:0]   d1l_mem [`EG_SLOTS];
	logic [`EG_TL_W-1:0]   tl_mem  [`EG_SLOTS];
	logic [`EG_KS_W-1:0]   ks_mem  [`EG_SLOTS];
	logic [`EG_KC_W-1:0]   kc_mem  [`EG_SLOTS];
	logic [`EG_SLOTS-1:0]  key_mem;  // key bit as written
	logic [`EG_SLOTS-1:0]  last_key; // key bit seen at last visit

	//////////////////////////////////////////////////
	// write side
	//////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `EG_SLOTS; i++) begin
				ar_mem[i]  <= '0;
				d1r_mem[i] <= '0;
				d2r_mem[i] <= '0;
				rr_mem[i]  <= '0;
				d1l_mem[i] <= '0;
				tl_mem[i]  <= '0;
				ks_mem[i]  <= '0;
				kc_mem[i]  <= '0;
			end
			key_mem <= '0; // all keys off
		end else if (wr) begin
			case (wr_op)
				op_ar:  ar_mem[wr_slot]  <= wr_data[`EG_RATE_W-1:0];
				op_d1r: d1r_mem[wr_slot] <= wr_data[`EG_RATE_W-1:0];
				op_d2r: d2r_mem[wr_slot] <= wr_data[`EG_RATE_W-1:0];
				op_rr_d1l: begin
					rr_mem[wr_slot]  <= wr_data[`EG_RR_W-1:0];
					d1l_mem[wr_slot] <= wr_data[`EG_DATA_W-1 -: `EG_RR_W]; // high nibble
				end
				op_tl: tl_mem[wr_slot] <= wr_data[`EG_TL_W-1:0];
				op_ks_kc: begin
					ks_mem[wr_slot] <= wr_data[`EG_DATA_W-1 -: `EG_KS_W]; // top bits
					kc_mem[wr_slot] <= wr_data[`EG_KC_W-1:0];
				end
				op_key: key_mem[wr_slot] <= wr_data[0];
				default: ; // unused opcode, ignored
			endcase
		end
	end

	//////////////////////////////////////////////////
	// read side, fields valid one clock after slot
	//////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		arate   <= ar_mem[slot];
		rate1   <= d1r_mem[slot];
		rate2   <= d2r_mem[slot];
		rrate   <= rr_mem[slot];
		d1l     <= d1l_mem[slot];
		tl      <= tl_mem[slot];
		ks      <= ks_mem[slot];
		keycode <= kc_mem[slot];
	end

	// key edges, one pulse per change at the slot's visit
	always_ff @(posedge clk) begin
		if (rst) begin
			keyon    <= 1'b0;
			keyoff   <= 1'b0;
			last_key <= '0;
		end else begin
			keyon          <= key_mem[slot] & ~last_key[slot];
			keyoff         <= ~key_mem[slot] & last_key[slot];
			last_key[slot] <= key_mem[slot]; // edge consumed
		end
	end

endmodule

`default_nettype wire

// ==== verilog/eg_slot_ring.sv ====
`default_nettype none
`timescale 1ns/1ps

module eg_slot_ring #(
	parameter int width  = 1,
	parameter int stages = 24  // at least 2
) (
	input  wire              clk,
	input  wire [width-1:0]  din,
	output logic [width-1:0] dout  // din from stages clocks back
);

	//////////////////////////////////////////////////
	// plain shift chain, no enable
	//////////////////////////////////////////////////
	logic [stages-1:0][width-1:0] sh;

	always_ff @(posedge clk) begin
		sh <= {sh[stages-2:0], din}; // shift one slot per clock
	end

	assign dout = sh[stages-1];

endmodule

`default_nettype wire

// ==== verilog/eg_timer.sv ====
`default_nettype none
`timescale 1ns/1ps
`include "eg_consts.svh"

module eg_timer (
	input  wire                   clk,
	input  wire                   rst,
	output logic [`EG_SLOT_W-1:0] slot,   // slot entering stage one
	output logic                  zero,   // first slot of the round
	output logic [`EG_CNT_W-1:0]  eg_cnt
);

	localparam logic [`EG_SLOT_W-1:0] last_slot = `EG_SLOT_W'(`EG_SLOTS - 1);

	logic [1:0] cnt_base; // rounds since last eg_cnt tick

	assign zero = (slot == '0);

	// round robin over all slots
	always_ff @(posedge clk) begin
		if (rst) begin
			slot <= '0;
		end else if (slot == last_slot) begin
			slot <= '0; // wrap
		end else begin
			slot <= slot + 1'b1;
		end
	end

	//////////////////////////////////////////////////
	// envelope counter, one tick per three rounds
	//////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (rst) begin
			cnt_base <= '0;
			eg_cnt   <= '0;
		end else if (zero) begin
			if (cnt_base == 2'd2) begin
				cnt_base <= '0;
				eg_cnt   <= eg_cnt + 1'b1; // every 72 clocks
			end else begin
				cnt_base <= cnt_base + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== verilog/eg_top.sv ====
`default_nettype none
`timescale 1ns/1ps
`include "eg_consts.svh"

module eg_top (
	input  wire                   clk,
	input  wire                   rst,
	input  wire                   wr,
	input  wire [`EG_SLOT_W-1:0]  wr_slot,
	input  var  eg_pkg::eg_op_t   wr_op,
	input  wire [`EG_DATA_W-1:0]  wr_data,
	output logic [`EG_W-1:0]      eg_out,
	output logic [`EG_SLOT_W-1:0] eg_out_slot, // slot of eg_out
	output logic                  eg_out_valid
);

	import eg_pkg::*;

	logic [`EG_SLOT_W-1:0]        slot;
	logic [`EG_CNT_W-1:0]         eg_cnt;
	logic [`EG_RATE_W-1:0]        arate, rate1, rate2, cfg_sel;
	logic [`EG_RR_W-1:0]          rrate, d1l;
	logic [`EG_TL_W-1:0]          tl;
	logic [`EG_KS_W-1:0]          ks;
	logic [`EG_KC_W-1:0]          keycode;
	logic                         keyon, keyoff, step, sum_up;
	logic [5:0]                   rate;
	eg_state_t                    state_sel;
	logic [4:0][`EG_SLOT_W-1:0]   slot_dly; // matches the five stages

	//////////////////////////////////////////////////
	// slot sequencing and register file
	//////////////////////////////////////////////////
	eg_timer u_timer (
		.clk (clk), .rst (rst),
		.slot (slot), .zero (), // round start not needed here
		.eg_cnt (eg_cnt)
	);

	eg_regs u_regs (
		.clk (clk), .rst (rst),
		.wr (wr), .wr_slot (wr_slot), .wr_op (wr_op), .wr_data (wr_data),
		.slot (slot),
		.arate (arate), .rate1 (rate1), .rate2 (rate2), .rrate (rrate),
		.d1l (d1l), .tl (tl), .ks (ks), .keycode (keycode),
		.keyon (keyon), .keyoff (keyoff)
	);

	//////////////////////////////////////////////////
	// rate unit and envelope core
	//////////////////////////////////////////////////
	eg_rate u_rate (
		.clk (clk), .rst (rst),
		.state (state_sel), .cfg (cfg_sel), .ks (ks), .keycode (keycode),
		.eg_cnt (eg_cnt),
		.rate (rate), .step (step), .sum_up (sum_up)
	);

	eg_core u_core (
		.clk (clk), .rst (rst),
		.keyon (keyon), .keyoff (keyoff),
		.arate (arate), .rate1 (rate1), .rate2 (rate2), .rrate (rrate),
		.d1l (d1l), .tl (tl),
		.state_sel (state_sel), .cfg_sel (cfg_sel),
		.rate (rate), .step (step), .sum_up (sum_up),
		.eg_out (eg_out), .eg_out_valid (eg_out_valid)
	);

	// slot index delay
	always_ff @(posedge clk) begin
		slot_dly <= {slot_dly[3:0], slot};
	end

	assign eg_out_slot = slot_dly[4];

endmodule

`default_nettype wire
